// ==== hw/display_scan.sv ====
`timescale 1ns/100ps

module display_scan
    import raster_pkg::*;
(
    input  logic                  clk_pix,
    input  logic                  i_reset,
    output logic [POS_W-1:0]      o_x,
    output logic [POS_W-1:0]      o_y,
    output logic                  o_de,
    output logic [FB_ADDR_W-1:0]  o_addr,
    output logic                  o_frame
);

    logic [POS_W-1:0] h_cnt;
    logic [POS_W-1:0] v_cnt;

    always_ff @(posedge clk_pix) begin
        if (i_reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == POS_W'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            if (v_cnt == POS_W'(V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign o_x     = h_cnt;
    assign o_y     = v_cnt;
    assign o_de    = (h_cnt < POS_W'(SCREEN_W)) && (v_cnt < POS_W'(SCREEN_H));
    assign o_frame = (h_cnt == '0) && (v_cnt == '0);

    // y * SCREEN_W + x, parked at 0 in blanking so the read stays in range
    assign o_addr = o_de ? FB_ADDR_W'(v_cnt) * FB_ADDR_W'(SCREEN_W) + FB_ADDR_W'(h_cnt)
                         : '0;

endmodule

// ==== hw/edge_eval.sv ====
`timescale 1ns/100ps

module edge_eval
    import raster_pkg::*;
(
    input  logic                       clk_pix,
    input  logic                       i_reset,
    input  logic [POS_W-1:0]           i_x,
    input  logic [POS_W-1:0]           i_y,
    input  logic                       i_valid,
    input  logic signed [COORD_W-1:0]  i_t0x,
    input  logic signed [COORD_W-1:0]  i_t0y,
    input  logic signed [COORD_W-1:0]  i_t1x,
    input  logic signed [COORD_W-1:0]  i_t1y,
    input  logic signed [COORD_W-1:0]  i_t2x,
    input  logic signed [COORD_W-1:0]  i_t2y,
    output logic                       o_inside
);

    logic signed [EDGE_W-1:0] px;
    logic signed [EDGE_W-1:0] py;
    logic signed [EDGE_W-1:0] e0;
    logic signed [EDGE_W-1:0] e1;
    logic signed [EDGE_W-1:0] e2;
    logic                     all_pos;
    logic                     all_neg;

    // (bx - ax)(y - ay) - (by - ay)(x - ax)
    function automatic logic signed [EDGE_W-1:0] edge_fn(
        input logic signed [COORD_W-1:0] ax,
        input logic signed [COORD_W-1:0] ay,
        input logic signed [COORD_W-1:0] bx,
        input logic signed [COORD_W-1:0] by,
        input logic signed [EDGE_W-1:0]  x,
        input logic signed [EDGE_W-1:0]  y
    );
        logic signed [EDGE_W-1:0] dx;
        logic signed [EDGE_W-1:0] dy;
        dx = EDGE_W'(bx) - EDGE_W'(ax);
        dy = EDGE_W'(by) - EDGE_W'(ay);
        return dx * (y - EDGE_W'(ay)) - dy * (x - EDGE_W'(ax));
    endfunction

    assign px = EDGE_W'($signed({1'b0, i_x}));   // scan position is unsigned
    assign py = EDGE_W'($signed({1'b0, i_y}));

    assign e0 = edge_fn(i_t0x, i_t0y, i_t1x, i_t1y, px, py);
    assign e1 = edge_fn(i_t1x, i_t1y, i_t2x, i_t2y, px, py);
    assign e2 = edge_fn(i_t2x, i_t2y, i_t0x, i_t0y, px, py);

    // either winding, edge pixels included
    assign all_pos = ~e0[EDGE_W-1] & ~e1[EDGE_W-1] & ~e2[EDGE_W-1];
    assign all_neg = (e0[EDGE_W-1] || e0 == '0)
                   && (e1[EDGE_W-1] || e1 == '0)
                   && (e2[EDGE_W-1] || e2 == '0);

    always_ff @(posedge clk_pix) begin
        if (i_reset) begin
            o_inside <= 1'b0;
        end else begin
            o_inside <= i_valid && (all_pos || all_neg);
        end
    end

endmodule

// ==== hw/frame_store.sv ====
`timescale 1ns/100ps

module frame_store
    import raster_pkg::*;
(
    input  logic                  clk_pix,
    input  logic                  i_reset,
    input  logic [FB_ADDR_W-1:0]  i_wr_addr,
    input  logic                  i_wr_valid,
    input  logic                  i_wr_clear,
    input  logic                  i_inside,    // already one cycle behind i_wr_addr
    input  logic [DEPTH_W-1:0]    i_depth,
    input  logic [CIDX_W-1:0]     i_cidx,
    input  logic [FB_ADDR_W-1:0]  i_rd_addr,
    output logic [CIDX_W-1:0]     o_rd_cidx
);

    logic [DEPTH_W-1:0]   depth_mem [PIX_COUNT];
    logic [CIDX_W-1:0]    cidx_mem  [PIX_COUNT];

    logic [FB_ADDR_W-1:0] addr_q;
    logic                 valid_q;
    logic                 clear_q;
    logic [DEPTH_W-1:0]   stored_q;    // depth currently at addr_q
    logic                 wr_en;
    logic [DEPTH_W-1:0]   wr_depth;
    logic [CIDX_W-1:0]    wr_cidx;

    // strict compare, equal depth keeps the old pixel
    assign wr_en    = valid_q && (clear_q || (i_inside && (i_depth < stored_q)));
    assign wr_depth = clear_q ? '1 : i_depth;    // far plane on clear
    assign wr_cidx  = clear_q ? CIDX_W'(CLEAR_INDEX) : i_cidx;

    always_ff @(posedge clk_pix) begin
        if (i_reset) begin
            valid_q <= 1'b0;
            clear_q <= 1'b0;
        end else begin
            valid_q <= i_wr_valid;
            clear_q <= i_wr_clear;
        end
    end

    // read stage of the read-compare-write
    always_ff @(posedge clk_pix) begin
        addr_q   <= i_wr_addr;
        stored_q <= depth_mem[i_wr_addr];
    end

    always_ff @(posedge clk_pix) begin
        if (wr_en) begin
            depth_mem[addr_q] <= wr_depth;
            cidx_mem[addr_q]  <= wr_cidx;
        end
    end

    // display port
    always_ff @(posedge clk_pix) begin
        o_rd_cidx <= cidx_mem[i_rd_addr];
    end

endmodule

// ==== hw/palette_out.sv ====
`timescale 1ns/100ps

module palette_out
    import raster_pkg::*;
(
    input  logic                  clk_pix,
    input  logic                  i_reset,
    input  logic [CIDX_W-1:0]     i_cidx,     // one cycle behind i_x/i_y
    input  logic [POS_W-1:0]      i_x,
    input  logic [POS_W-1:0]      i_y,
    input  logic                  i_de,
    input  logic                  i_frame,
    output logic [POS_W-1:0]      o_sx,
    output logic [POS_W-1:0]      o_sy,
    output logic                  o_de,
    output logic                  o_frame,
    output logic [2*CHAN_W-1:0]   o_r,
    output logic [2*CHAN_W-1:0]   o_g,
    output logic [2*CHAN_W-1:0]   o_b
);

    logic [POS_W-1:0]    x_d1;
    logic [POS_W-1:0]    y_d1;
    logic                de_d1;
    logic                frame_d1;
    logic [3*CHAN_W-1:0] rgb;
    logic [CHAN_W-1:0]   red;
    logic [CHAN_W-1:0]   grn;
    logic [CHAN_W-1:0]   blu;

    assign rgb             = PALETTE[i_cidx];
    assign {red, grn, blu} = rgb;

    always_ff @(posedge clk_pix) begin
        if (i_reset) begin
            x_d1     <= '0;
            y_d1     <= '0;
            de_d1    <= 1'b0;
            frame_d1 <= 1'b0;
            o_sx     <= '0;
            o_sy     <= '0;
            o_de     <= 1'b0;
            o_frame  <= 1'b0;
            o_r      <= '0;
            o_g      <= '0;
            o_b      <= '0;
        end else begin
            x_d1     <= i_x;        // lines up with i_cidx
            y_d1     <= i_y;
            de_d1    <= i_de;
            frame_d1 <= i_frame;
            o_sx     <= x_d1;
            o_sy     <= y_d1;
            o_de     <= de_d1;
            o_frame  <= frame_d1;
            o_r      <= de_d1 ? {2{red}} : '0;   // 4 to 8 bits by doubling
            o_g      <= de_d1 ? {2{grn}} : '0;
            o_b      <= de_d1 ? {2{blu}} : '0;
        end
    end

endmodule

// ==== hw/raster_ctrl.sv ====
`timescale 1ns/100ps

module raster_ctrl
    import raster_pkg::*;
(
    input  logic                       clk_pix,
    input  logic                       i_reset,
    input  logic                       i_draw,
    input  logic                       i_clear,
    input  logic signed [COORD_W-1:0]  i_v0x,
    input  logic signed [COORD_W-1:0]  i_v0y,
    input  logic signed [COORD_W-1:0]  i_v1x,
    input  logic signed [COORD_W-1:0]  i_v1y,
    input  logic signed [COORD_W-1:0]  i_v2x,
    input  logic signed [COORD_W-1:0]  i_v2y,
    input  logic [DEPTH_W-1:0]         i_depth,
    input  logic [CIDX_W-1:0]          i_cidx,
    output logic                       o_busy,
    output logic                       o_done,
    output logic [POS_W-1:0]           o_sweep_x,
    output logic [POS_W-1:0]           o_sweep_y,
    output logic [FB_ADDR_W-1:0]       o_sweep_addr,
    output logic                       o_sweep_valid,
    output logic                       o_sweep_clear,
    output logic signed [COORD_W-1:0]  o_t0x,
    output logic signed [COORD_W-1:0]  o_t0y,
    output logic signed [COORD_W-1:0]  o_t1x,
    output logic signed [COORD_W-1:0]  o_t1y,
    output logic signed [COORD_W-1:0]  o_t2x,
    output logic signed [COORD_W-1:0]  o_t2y,
    output logic [DEPTH_W-1:0]         o_t_depth,
    output logic [CIDX_W-1:0]          o_t_cidx
);

    // state lives in o_busy, o_sweep_valid and drain_q
    logic drain_q;
    logic drain_cnt;      // two drain cycles
    logic start_clear;
    logic start_draw;
    logic last_pix;

    assign start_clear = ~o_busy & i_clear;
    assign start_draw  = ~o_busy & i_draw & ~i_clear;   // clear wins
    assign last_pix    = (o_sweep_addr == FB_ADDR_W'(PIX_COUNT - 1));

    always_ff @(posedge clk_pix) begin
        if (i_reset) begin
            o_busy        <= 1'b0;
            o_done        <= 1'b0;
            o_sweep_valid <= 1'b0;
            o_sweep_clear <= 1'b0;
            o_sweep_x     <= '0;
            o_sweep_y     <= '0;
            o_sweep_addr  <= '0;
            drain_q       <= 1'b0;
            drain_cnt     <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (start_clear || start_draw) begin
                o_busy        <= 1'b1;
                o_sweep_valid <= 1'b1;
                o_sweep_clear <= start_clear;
                o_sweep_x     <= '0;
                o_sweep_y     <= '0;
                o_sweep_addr  <= '0;
            end else if (o_sweep_valid) begin
                if (last_pix) begin
                    o_sweep_valid <= 1'b0;
                    drain_q       <= 1'b1;
                    drain_cnt     <= 1'b0;
                end else begin
                    o_sweep_addr <= o_sweep_addr + 1'b1;
                    if (o_sweep_x == POS_W'(SCREEN_W - 1)) begin
                        o_sweep_x <= '0;
                        o_sweep_y <= o_sweep_y + 1'b1;
                    end else begin
                        o_sweep_x <= o_sweep_x + 1'b1;
                    end
                end
            end else if (drain_q) begin
                // let the last pixel pass edge test and depth write
                drain_cnt <= 1'b1;
                if (drain_cnt) begin
                    drain_q       <= 1'b0;
                    o_busy        <= 1'b0;
                    o_done        <= 1'b1;
                    o_sweep_clear <= 1'b0;
                end
            end
        end
    end

    // triangle held for the whole sweep
    always_ff @(posedge clk_pix) begin
        if (start_draw) begin
            o_t0x     <= i_v0x;
            o_t0y     <= i_v0y;
            o_t1x     <= i_v1x;
            o_t1y     <= i_v1y;
            o_t2x     <= i_v2x;
            o_t2y     <= i_v2y;
            o_t_depth <= i_depth;
            o_t_cidx  <= i_cidx;
        end
    end

endmodule

// ==== hw/raster_pkg.sv ====
package raster_pkg;

    // screen and scan timing
    localparam int unsigned SCREEN_W  = 32;    // active pixels per line
    localparam int unsigned SCREEN_H  = 24;    // active lines per frame
    localparam int unsigned H_TOTAL   = 40;    // line period incl. blanking
    localparam int unsigned V_TOTAL   = 28;    // frame period in lines
    localparam int unsigned PIX_COUNT = SCREEN_W * SCREEN_H;

    // widths
    localparam int unsigned FB_ADDR_W = 10;
    localparam int unsigned COORD_W   = 8;     // signed vertex coords
    localparam int unsigned POS_W     = 6;     // holds 0..H_TOTAL-1
    localparam int unsigned EDGE_W    = 19;
    localparam int unsigned DEPTH_W   = 8;     // smaller is nearer, all ones is far
    localparam int unsigned CIDX_W    = 4;
    localparam int unsigned CHAN_W    = 4;

    localparam int unsigned CLEAR_INDEX = 10;

    // 12-bit colours, red in the top nibble, then green, then blue
    localparam logic [3*CHAN_W-1:0] PALETTE [16] = '{
        12'h000,    // 0 black
        12'h123,
        12'h725,
        12'h085,
        12'ha53,
        12'h554,
        12'hccc,
        12'hffe,    // 7 near white
        12'hf05,
        12'hfa0,
        12'hfe2,    // 10 yellow, clear colour
        12'h0e3,
        12'h2af,
        12'h879,
        12'hf7a,
        12'hfca
    };

endpackage

// ==== hw/raster_top.sv ====
`timescale 1ns/100ps

module raster_top
    import raster_pkg::*;
(
    input  logic                       clk_pix,
    input  logic                       i_reset,
    input  logic signed [COORD_W-1:0]  i_v0x,
    input  logic signed [COORD_W-1:0]  i_v0y,
    input  logic signed [COORD_W-1:0]  i_v1x,
    input  logic signed [COORD_W-1:0]  i_v1y,
    input  logic signed [COORD_W-1:0]  i_v2x,
    input  logic signed [COORD_W-1:0]  i_v2y,
    input  logic [DEPTH_W-1:0]         i_depth,
    input  logic [CIDX_W-1:0]          i_cidx,
    input  logic                       i_draw,
    input  logic                       i_clear,
    output logic                       o_busy,
    output logic                       o_done,
    output logic [POS_W-1:0]           o_sx,
    output logic [POS_W-1:0]           o_sy,
    output logic                       o_de,
    output logic                       o_frame,
    output logic [2*CHAN_W-1:0]        o_r,
    output logic [2*CHAN_W-1:0]        o_g,
    output logic [2*CHAN_W-1:0]        o_b
);

    // draw side
    logic [POS_W-1:0]          sweep_x;
    logic [POS_W-1:0]          sweep_y;
    logic [FB_ADDR_W-1:0]      sweep_addr;
    logic                      sweep_valid;
    logic                      sweep_clear;
    logic signed [COORD_W-1:0] t0x;
    logic signed [COORD_W-1:0] t0y;
    logic signed [COORD_W-1:0] t1x;
    logic signed [COORD_W-1:0] t1y;
    logic signed [COORD_W-1:0] t2x;
    logic signed [COORD_W-1:0] t2y;
    logic [DEPTH_W-1:0]        t_depth;
    logic [CIDX_W-1:0]         t_cidx;
    logic                      inside_hit;

    // scan side
    logic [POS_W-1:0]          scan_x;
    logic [POS_W-1:0]          scan_y;
    logic                      scan_de;
    logic [FB_ADDR_W-1:0]      scan_addr;
    logic                      scan_frame;
    logic [CIDX_W-1:0]         rd_cidx;

    raster_ctrl i_raster_ctrl (
        .clk_pix       (clk_pix),
        .i_reset       (i_reset),
        .i_draw        (i_draw),
        .i_clear       (i_clear),
        .i_v0x         (i_v0x),
        .i_v0y         (i_v0y),
        .i_v1x         (i_v1x),
        .i_v1y         (i_v1y),
        .i_v2x         (i_v2x),
        .i_v2y         (i_v2y),
        .i_depth       (i_depth),
        .i_cidx        (i_cidx),
        .o_busy        (o_busy),
        .o_done        (o_done),
        .o_sweep_x     (sweep_x),
        .o_sweep_y     (sweep_y),
        .o_sweep_addr  (sweep_addr),
        .o_sweep_valid (sweep_valid),
        .o_sweep_clear (sweep_clear),
        .o_t0x         (t0x),
        .o_t0y         (t0y),
        .o_t1x         (t1x),
        .o_t1y         (t1y),
        .o_t2x         (t2x),
        .o_t2y         (t2y),
        .o_t_depth     (t_depth),
        .o_t_cidx      (t_cidx)
    );

    edge_eval i_edge_eval (
        .clk_pix  (clk_pix),
        .i_reset  (i_reset),
        .i_x      (sweep_x),
        .i_y      (sweep_y),
        .i_valid  (sweep_valid),
        .i_t0x    (t0x),
        .i_t0y    (t0y),
        .i_t1x    (t1x),
        .i_t1y    (t1y),
        .i_t2x    (t2x),
        .i_t2y    (t2y),
        .o_inside (inside_hit)
    );

    frame_store i_frame_store (
        .clk_pix    (clk_pix),
        .i_reset    (i_reset),
        .i_wr_addr  (sweep_addr),
        .i_wr_valid (sweep_valid),
        .i_wr_clear (sweep_clear),
        .i_inside   (inside_hit),
        .i_depth    (t_depth),
        .i_cidx     (t_cidx),
        .i_rd_addr  (scan_addr),
        .o_rd_cidx  (rd_cidx)
    );

    display_scan i_display_scan (
        .clk_pix (clk_pix),
        .i_reset (i_reset),
        .o_x     (scan_x),
        .o_y     (scan_y),
        .o_de    (scan_de),
        .o_addr  (scan_addr),
        .o_frame (scan_frame)
    );

    palette_out i_palette_out (
        .clk_pix (clk_pix),
        .i_reset (i_reset),
        .i_cidx  (rd_cidx),
        .i_x     (scan_x),
        .i_y     (scan_y),
        .i_de    (scan_de),
        .i_frame (scan_frame),
        .o_sx    (o_sx),
        .o_sy    (o_sy),
        .o_de    (o_de),
        .o_frame (o_frame),
        .o_r     (o_r),
        .o_g     (o_g),
        .o_b     (o_b)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the tri_raster testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -j 0 \
    --top-module raster_top_tb -Mdir obj_dir -f tri_raster.f \
    && ./obj_dir/Vraster_top_tb 2>&1 | tee "$LOG" \
    || echo "compile or simulation step returned an error"

grep -qx "Verification passed" "$LOG" 2>/dev/null \
    && echo "run_sim: simulation passed" \
    && exit 0 \
    || { echo "run_sim: simulation failed, see $LOG"; exit 1; }

// ==== tests/raster_top_props.sv ====
`timescale 1ns/100ps

module raster_top_props
    import raster_pkg::*;
(
    input logic              clk_pix,
    input logic              i_reset,
    input logic              i_busy,
    input logic              i_done,
    input logic [POS_W-1:0]  i_sx,
    input logic [POS_W-1:0]  i_sy,
    input logic              i_de,
    input logic              i_frame
);

    done_single: assert property (@(posedge clk_pix) disable iff (i_reset)
        i_done |=> !i_done)
        else $error("o_done stayed high for more than one cycle");

    // host may strobe again only after this
    idle_after_done: assert property (@(posedge clk_pix) disable iff (i_reset)
        i_done |=> !i_busy)
        else $error("o_busy was high in the cycle after o_done");

    de_in_active: assert property (@(posedge clk_pix) disable iff (i_reset)
        i_de |-> (i_sx < POS_W'(SCREEN_W)) && (i_sy < POS_W'(SCREEN_H)))
        else $error("o_de high outside the active area");

    frame_at_origin: assert property (@(posedge clk_pix) disable iff (i_reset)
        i_frame |-> (i_sx == '0) && (i_sy == '0))
        else $error("o_frame high away from position zero");

endmodule

// ==== tests/raster_top_tb.sv ====
`timescale 1ns/100ps

module raster_top_tb
    import raster_pkg::*;
();

    localparam logic [31:0] SEED = 32'h8dea;
    localparam int DONE_TIMEOUT  = int'(PIX_COUNT) + 64;
    localparam int FRAME_TIMEOUT = 3 * int'(H_TOTAL * V_TOTAL);

    logic                       clk_pix;
    logic                       i_reset;
    logic signed [COORD_W-1:0]  i_v0x;
    logic signed [COORD_W-1:0]  i_v0y;
    logic signed [COORD_W-1:0]  i_v1x;
    logic signed [COORD_W-1:0]  i_v1y;
    logic signed [COORD_W-1:0]  i_v2x;
    logic signed [COORD_W-1:0]  i_v2y;
    logic [DEPTH_W-1:0]         i_depth;
    logic [CIDX_W-1:0]          i_cidx;
    logic                       i_draw;
    logic                       i_clear;
    logic                       o_busy;
    logic                       o_done;
    logic [POS_W-1:0]           o_sx;
    logic [POS_W-1:0]           o_sy;
    logic                       o_de;
    logic                       o_frame;
    logic [2*CHAN_W-1:0]        o_r;
    logic [2*CHAN_W-1:0]        o_g;
    logic [2*CHAN_W-1:0]        o_b;

    // triangle being sent and the model image
    int          tri_x [3];
    int          tri_y [3];
    int          tri_depth;
    int          tri_cidx;
    int          model_depth [PIX_COUNT];
    int          model_cidx  [PIX_COUNT];
    logic [31:0] rng_state;
    string       test_name;
    int          errors;
    int          accepted;
    int          done_count;
    int          pix_seen;
    int          pix_total;
    int          scan_cycles;
    int          exp_x;
    int          exp_y;
    logic        exp_de;
    logic        arm;
    logic        checking;
    logic        frame_checked;
    logic [23:0] exp_rgb;
    logic [23:0] act_rgb;

    tb_clock_gen #(.PERIOD_NS(40)) i_clock_gen (.o_clk(clk_pix));

    raster_top i_raster_top (
        .clk_pix (clk_pix),
        .i_reset (i_reset),
        .i_v0x   (i_v0x),
        .i_v0y   (i_v0y),
        .i_v1x   (i_v1x),
        .i_v1y   (i_v1y),
        .i_v2x   (i_v2x),
        .i_v2y   (i_v2y),
        .i_depth (i_depth),
        .i_cidx  (i_cidx),
        .i_draw  (i_draw),
        .i_clear (i_clear),
        .o_busy  (o_busy),
        .o_done  (o_done),
        .o_sx    (o_sx),
        .o_sy    (o_sy),
        .o_de    (o_de),
        .o_frame (o_frame),
        .o_r     (o_r),
        .o_g     (o_g),
        .o_b     (o_b)
    );

    bind raster_top raster_top_props i_raster_top_props (
        .clk_pix (clk_pix),
        .i_reset (i_reset),
        .i_busy  (o_busy),
        .i_done  (o_done),
        .i_sx    (o_sx),
        .i_sy    (o_sy),
        .i_de    (o_de),
        .i_frame (o_frame)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] t;
        t = s ^ (s << 13);
        t = t ^ (t >> 17);
        t = t ^ (t << 5);
        return t;
    endfunction

    function automatic int rand_below(input int n);
        rng_state = xorshift32(rng_state);
        return int'(rng_state % 32'(n));
    endfunction

    function automatic int edge_value(input int ax, input int ay, input int bx, input int by,
                                      input int x, input int y);
        return (bx - ax) * (y - ay) - (by - ay) * (x - ax);
    endfunction

    // either winding, zero counts as inside
    function automatic bit covers(input int x, input int y);
        int e0;
        int e1;
        int e2;
        e0 = edge_value(tri_x[0], tri_y[0], tri_x[1], tri_y[1], x, y);
        e1 = edge_value(tri_x[1], tri_y[1], tri_x[2], tri_y[2], x, y);
        e2 = edge_value(tri_x[2], tri_y[2], tri_x[0], tri_y[0], x, y);
        return (e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0);
    endfunction

    // palette colour, each nibble doubled
    function automatic logic [23:0] expected_rgb(input int x, input int y);
        logic [11:0] c;
        c = PALETTE[model_cidx[y * int'(SCREEN_W) + x]];
        return {c[11:8], c[11:8], c[7:4], c[7:4], c[3:0], c[3:0]};
    endfunction

    task automatic model_clear();
        for (int a = 0; a < int'(PIX_COUNT); a++) begin
            model_depth[a] = 255;    // far plane
            model_cidx[a]  = int'(CLEAR_INDEX);
        end
    endtask

    task automatic model_draw();
        int a;
        for (int y = 0; y < int'(SCREEN_H); y++) begin
            for (int x = 0; x < int'(SCREEN_W); x++) begin
                a = y * int'(SCREEN_W) + x;
                if (covers(x, y) && tri_depth < model_depth[a]) begin
                    model_depth[a] = tri_depth;
                    model_cidx[a]  = tri_cidx;
                end
            end
        end
    endtask

    task automatic report_mismatch(input string what, input int expected, input int actual);
        errors++;
        $display("[ERROR] %s: %s expected 0x%0h actual 0x%0h",
                 test_name, what, expected, actual);
    endtask

    task automatic report_issue(input string what);
        errors++;
        $display("[ERROR] %s: %s", test_name, what);
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout in %s: %s, %0d errors so far", test_name, what, errors);
        $display("Verification failed");
        $finish;
    endtask

    task automatic set_triangle(input int x0, input int y0, input int x1, input int y1,
                                input int x2, input int y2, input int d, input int c);
        tri_x[0]  = x0;
        tri_y[0]  = y0;
        tri_x[1]  = x1;
        tri_y[1]  = y1;
        tri_x[2]  = x2;
        tri_y[2]  = y2;
        tri_depth = d;
        tri_cidx  = c;
    endtask

    task automatic swap_winding();
        int t;
        t        = tri_x[1];
        tri_x[1] = tri_x[2];
        tri_x[2] = t;
        t        = tri_y[1];
        tri_y[1] = tri_y[2];
        tri_y[2] = t;
    endtask

    task automatic random_triangle();
        for (int i = 0; i < 3; i++) begin
            tri_x[i] = rand_below(48) - 8;    // -8..39
            tri_y[i] = rand_below(48) - 8;
        end
        tri_depth = rand_below(255);
        tri_cidx  = rand_below(16);
        if (tri_cidx == int'(CLEAR_INDEX)) begin
            tri_cidx = 0;                    // keep it visible
        end
    endtask

    // one-cycle strobe with the triangle on the inputs
    task automatic start_sweep(input logic draw, input logic clear);
        @(posedge clk_pix);
        i_v0x   <= COORD_W'(tri_x[0]);
        i_v0y   <= COORD_W'(tri_y[0]);
        i_v1x   <= COORD_W'(tri_x[1]);
        i_v1y   <= COORD_W'(tri_y[1]);
        i_v2x   <= COORD_W'(tri_x[2]);
        i_v2y   <= COORD_W'(tri_y[2]);
        i_depth <= DEPTH_W'(tri_depth);
        i_cidx  <= CIDX_W'(tri_cidx);
        i_draw  <= draw;
        i_clear <= clear;
        @(posedge clk_pix);
        i_draw  <= 1'b0;
        i_clear <= 1'b0;
    endtask

    task automatic wait_done(output int busy_n);
        int n;
        busy_n = 0;
        n = 0;
        @(negedge clk_pix);
        while (!o_done && n < DONE_TIMEOUT) begin
            if (o_busy) begin
                busy_n++;
            end
            n++;
            @(negedge clk_pix);
        end
        if (!o_done) begin
            timeout_fail("o_done did not pulse");
        end else begin
            @(negedge clk_pix);
            assert (!o_busy) else report_issue("o_busy rose again right after o_done");
            assert (done_count == accepted)
                else report_mismatch("o_done pulses", accepted, done_count);
        end
    endtask

    task automatic run_sweep(input logic draw, input logic clear);
        int busy_n;
        start_sweep(draw, clear);
        accepted++;
        if (clear) begin
            model_clear();                   // clear wins over draw
        end else begin
            model_draw();
        end
        wait_done(busy_n);
        assert (busy_n == int'(PIX_COUNT) + 2)
            else report_mismatch("busy cycles", int'(PIX_COUNT) + 2, busy_n);
    endtask

    task automatic check_frame();
        int n;
        frame_checked = 1'b0;
        @(posedge clk_pix);
        arm = 1'b1;
        n = 0;
        while (!frame_checked && n < FRAME_TIMEOUT) begin
            @(posedge clk_pix);
            n++;
        end
        if (!frame_checked) begin
            timeout_fail("no complete frame came out of the scanner");
        end else begin
            assert (pix_seen == int'(PIX_COUNT))
                else report_mismatch("active pixels in frame", int'(PIX_COUNT), pix_seen);
        end
    endtask

    always @(negedge clk_pix) begin
        if (o_done) begin
            done_count++;
        end
    end

    // compares one whole frame, starting at o_frame
    always @(negedge clk_pix) begin
        if (arm && o_frame) begin
            arm         = 1'b0;
            checking    = 1'b1;
            scan_cycles = 0;
            pix_seen    = 0;
        end
        if (checking) begin
            exp_x   = scan_cycles % int'(H_TOTAL);    // raster order from the origin
            exp_y   = scan_cycles / int'(H_TOTAL);
            exp_de  = (exp_x < int'(SCREEN_W)) && (exp_y < int'(SCREEN_H));
            act_rgb = {o_r, o_g, o_b};
            assert (int'(o_sx) == exp_x)
                else report_mismatch("scan x", exp_x, int'(o_sx));
            assert (int'(o_sy) == exp_y)
                else report_mismatch("scan y", exp_y, int'(o_sy));
            assert (o_de == exp_de)
                else report_mismatch($sformatf("o_de at (%0d,%0d)", exp_x, exp_y),
                                     int'(exp_de), int'(o_de));
            if (o_de) begin
                exp_rgb = expected_rgb(int'(o_sx), int'(o_sy));
                pix_seen++;
                pix_total++;
                assert (act_rgb == exp_rgb)
                    else report_mismatch($sformatf("pixel (%0d,%0d)", o_sx, o_sy),
                                         int'(exp_rgb), int'(act_rgb));
            end else begin
                assert (act_rgb == '0)
                    else report_mismatch("colour in blanking", 0, int'(act_rgb));
            end
            scan_cycles++;
            if (scan_cycles == int'(H_TOTAL * V_TOTAL)) begin
                checking      = 1'b0;
                frame_checked = 1'b1;
            end
        end
    end

    initial begin
        int busy_n;
        i_reset       <= 1'b1;
        i_v0x         <= '0;
        i_v0y         <= '0;
        i_v1x         <= '0;
        i_v1y         <= '0;
        i_v2x         <= '0;
        i_v2y         <= '0;
        i_depth       <= '0;
        i_cidx        <= '0;
        i_draw        <= 1'b0;
        i_clear       <= 1'b0;
        rng_state     = SEED;
        errors        = 0;
        accepted      = 0;
        done_count    = 0;
        pix_total     = 0;
        arm           = 1'b0;
        checking      = 1'b0;
        frame_checked = 1'b0;
        set_triangle(0, 0, 0, 0, 0, 0, 0, 0);
        repeat (16) @(posedge clk_pix);
        i_reset <= 1'b0;

        test_name = "clear";
        run_sweep(1'b0, 1'b1);
        check_frame();

        // right angle at the origin puts many pixels on edges
        test_name = "edge_pixels";
        for (int w = 0; w < 2; w++) begin
            run_sweep(1'b0, 1'b1);
            set_triangle(0, 0, 20, 0, 0, 20, 40, 5);
            if (w == 1) begin
                swap_winding();
            end
            run_sweep(1'b1, 1'b0);
            check_frame();
        end

        test_name = "single_triangle";
        for (int i = 0; i < 6; i++) begin
            run_sweep(1'b0, 1'b1);
            random_triangle();
            if (i % 2 == 1) begin
                swap_winding();
            end
            run_sweep(1'b1, 1'b0);
            check_frame();
        end

        test_name = "depth_order";
        run_sweep(1'b0, 1'b1);
        set_triangle(2, 2, 28, 4, 10, 20, 100, 3);
        run_sweep(1'b1, 1'b0);
        set_triangle(5, 1, 30, 18, 4, 22, 50, 12);     // nearer, covers
        run_sweep(1'b1, 1'b0);
        set_triangle(-4, 0, 31, 0, 16, 23, 200, 8);    // farther, mostly hidden
        run_sweep(1'b1, 1'b0);
        set_triangle(5, 1, 30, 18, 4, 22, 50, 14);     // same depth, no overwrite
        run_sweep(1'b1, 1'b0);
        check_frame();

        test_name = "busy_strobes";
        run_sweep(1'b0, 1'b1);
        set_triangle(3, 3, 25, 6, 12, 21, 60, 9);
        start_sweep(1'b1, 1'b0);
        accepted++;
        model_draw();
        repeat (20) @(posedge clk_pix);
        set_triangle(0, 0, 31, 0, 0, 23, 10, 2);
        start_sweep(1'b1, 1'b1);    // mid-sweep, must be dropped
        repeat (20) @(posedge clk_pix);
        start_sweep(1'b1, 1'b0);    // mid-sweep draw, triangle not captured
        wait_done(busy_n);
        check_frame();

        test_name = "draw_with_clear";
        start_sweep(1'b1, 1'b1);
        accepted++;
        model_clear();
        wait_done(busy_n);
        check_frame();

        $display("pixels compared %0d, errors %0d", pix_total, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2);
        o_clk = ~o_clk;    // 50 % duty
    end

endmodule

// ==== tri_raster.f ====
hw/raster_pkg.sv
hw/raster_ctrl.sv
hw/edge_eval.sv
hw/frame_store.sv
hw/display_scan.sv
hw/palette_out.sv
hw/raster_top.sv
tests/tb_clock_gen.sv
tests/raster_top_props.sv
tests/raster_top_tb.sv
